/* rtl/pixel_cfg_pkg.sv */
// Widths, field positions, status bit indices, types and sequencer states
`default_nettype none

package pixel_cfg_pkg;

  // Sizes --------------------
  localparam int CFG_WORDS  = 16;   // Configuration array depth
  localparam int CHAIN_BITS = 256;  // Serial chain length, CFG_WORDS x 16
  localparam int CAP_WORDS  = 8;    // Captured 32-bit words

  typedef logic [23:0]           operand_t;     // SW operand and static register
  typedef logic [31:0]           data_word_t;   // Read data and status
  typedef logic [15:0]           array_word_t;
  typedef logic [3:0]            array_addr_t;
  typedef logic [2:0]            cap_addr_t;
  typedef logic [6:0]            period_t;      // Configclk period, delay, sample
  typedef logic [CHAIN_BITS-1:0] chain_t;
  typedef logic [8:0]            shift_cnt_t;

  // Static register 0 fields --------------------
  localparam int FAST_PERIOD_LSB   = 0;
  localparam int FAST_PERIOD_MSB   = 6;
  localparam int SUPER_PIX_SEL_BIT = 7;

  // Execute operand fields --------------------
  localparam int TEST_DELAY_LSB          = 0;
  localparam int TEST_DELAY_MSB          = 6;
  localparam int TEST_SAMPLE_LSB         = 7;
  localparam int TEST_SAMPLE_MSB         = 13;
  localparam int TEST_NUMBER_LSB         = 14;
  localparam int TEST_NUMBER_MSB         = 17;
  localparam int TEST_LOOPBACK_BIT       = 18;  // Capture config_in instead of config_out
  localparam int TEST_MASK_RESET_NOT_BIT = 23;  // Skip the reset_not pulse
  localparam int ADDR_LSB                = 16;  // Read/write address starts here

  localparam logic [3:0] TEST_SHIFT_CHAIN = 4'd1;

  // Status word bits --------------------
  localparam int ST_RESET    = 0;
  localparam int ST_W_STATIC = 1;
  localparam int ST_R_STATIC = 2;
  localparam int ST_W_ARRAY  = 5;
  localparam int ST_R_ARRAY  = 6;
  localparam int ST_R_DATA   = 9;
  localparam int ST_EXECUTE  = 11;
  localparam int ST_DONE     = 12;
  localparam int ST_ERROR    = 31;

  typedef enum logic [1:0] {
    SEQ_IDLE,       // Pins parked at 0
    SEQ_RESET_NOT,  // One configclk period with reset_not low
    SEQ_SHIFT,      // Chain shifting
    SEQ_DONE
  } seq_state_t;

endpackage

`default_nettype wire

/* rtl/command_decoder.sv */
// Op-code gating by device enable and chain test start with latched test fields
`default_nettype none
`timescale 1ns/100ps

module command_decoder (
  input  logic                   fw_axi_clk,
  input  logic                   op_code_w_reset,
  input  logic                   fw_dev_id_enable,
  input  logic                   fw_op_code_w_cfg_static_0,
  input  logic                   fw_op_code_r_cfg_static_0,
  input  logic                   fw_op_code_w_cfg_array_0,
  input  logic                   fw_op_code_r_cfg_array_0,
  input  logic                   fw_op_code_r_data_array_0,
  input  logic                   fw_op_code_w_status_clear,
  input  logic                   fw_op_code_w_execute,
  input  pixel_cfg_pkg::operand_t sw_write24_0,
  output logic                   wr_static,
  output logic                   rd_static,
  output logic                   wr_array,
  output logic                   rd_array,
  output logic                   rd_data,
  output logic                   status_clear,
  output logic                   execute,
  output logic                   test_start,
  output pixel_cfg_pkg::period_t test_delay,
  output pixel_cfg_pkg::period_t test_sample,
  output logic                   test_loopback,
  output logic                   test_mask_reset_not
);
  import pixel_cfg_pkg::*;

  logic execute_q;   // Previous gated execute
  logic chain_exec;  // Rising execute for the chain test

  // Only the enabled device sees the strobes
  assign wr_static    = fw_dev_id_enable & fw_op_code_w_cfg_static_0;
  assign rd_static    = fw_dev_id_enable & fw_op_code_r_cfg_static_0;
  assign wr_array     = fw_dev_id_enable & fw_op_code_w_cfg_array_0;
  assign rd_array     = fw_dev_id_enable & fw_op_code_r_cfg_array_0;
  assign rd_data      = fw_dev_id_enable & fw_op_code_r_data_array_0;
  assign status_clear = fw_dev_id_enable & fw_op_code_w_status_clear;
  assign execute      = fw_dev_id_enable & fw_op_code_w_execute;

  assign chain_exec = execute & ~execute_q
                    & (sw_write24_0[TEST_NUMBER_MSB:TEST_NUMBER_LSB] == TEST_SHIFT_CHAIN);

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      execute_q           <= 1'b0;
      test_start          <= 1'b0;
      test_delay          <= '0;
      test_sample         <= '0;
      test_loopback       <= 1'b0;
      test_mask_reset_not <= 1'b0;
    end else begin
      execute_q  <= execute;
      test_start <= chain_exec;  // One-cycle pulse
      if (chain_exec) begin      // Fields held for the whole test
        test_delay          <= sw_write24_0[TEST_DELAY_MSB:TEST_DELAY_LSB];
        test_sample         <= sw_write24_0[TEST_SAMPLE_MSB:TEST_SAMPLE_LSB];
        test_loopback       <= sw_write24_0[TEST_LOOPBACK_BIT];
        test_mask_reset_not <= sw_write24_0[TEST_MASK_RESET_NOT_BIT];
      end
    end
  end

  // Software issues at most one op-code per cycle
  a_one_strobe: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    $onehot0({wr_static, rd_static, wr_array, rd_array, rd_data, status_clear, execute}));

endmodule

`default_nettype wire

/* rtl/config_regs.sv */
// Static register 0 and the configuration word array written by software
`default_nettype none
`timescale 1ns/100ps

module config_regs (
  input  logic                      fw_axi_clk,
  input  logic                      op_code_w_reset,
  input  logic                      wr_static,
  input  logic                      wr_array,
  input  pixel_cfg_pkg::operand_t    sw_write24_0,
  output pixel_cfg_pkg::operand_t    static_0,
  output pixel_cfg_pkg::array_word_t cfg_array [pixel_cfg_pkg::CFG_WORDS]
);
  import pixel_cfg_pkg::*;

  array_addr_t wr_addr;  // Operand bits 19:16

  assign wr_addr = sw_write24_0[ADDR_LSB +: $bits(array_addr_t)];

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_0 <= '0;
      for (int i = 0; i < CFG_WORDS; i++) begin
        cfg_array[i] <= '0;
      end
    end else begin
      if (wr_static) begin
        static_0 <= sw_write24_0;  // Visible to a read in the next cycle
      end
      if (wr_array) begin
        cfg_array[wr_addr] <= sw_write24_0[$bits(array_word_t)-1:0];  // Low half is data
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/configclk_generator.sv */
// Period counter and fast configuration clock
`default_nettype none
`timescale 1ns/100ps

module configclk_generator (
  input  logic                   fw_axi_clk,
  input  logic                   op_code_w_reset,
  input  pixel_cfg_pkg::period_t period,
  output pixel_cfg_pkg::period_t clk_counter,
  output logic                   configclk
);
  import pixel_cfg_pkg::*;

  // Counts 0..period, so one configclk is period+1 cycles
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || clk_counter >= period) begin
      clk_counter <= '0;
    end else begin
      clk_counter <= clk_counter + 1'b1;
    end
  end

  // High in the upper half of the count
  assign configclk = (clk_counter > (period >> 1));

  // Counter never passes a settled period
  a_cnt_wrap: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    $stable(period) |-> (clk_counter <= period));

endmodule

`default_nettype wire

/* rtl/config_shift_sequencer.sv */
// Chain test FSM, serial shift register and ASIC pin drive
`default_nettype none
`timescale 1ns/100ps

module config_shift_sequencer (
  input  logic                      fw_axi_clk,
  input  logic                      op_code_w_reset,
  input  logic                      test_start,
  input  pixel_cfg_pkg::period_t     test_delay,
  input  pixel_cfg_pkg::period_t     test_sample,
  input  logic                      test_mask_reset_not,
  input  pixel_cfg_pkg::period_t     period,
  input  pixel_cfg_pkg::period_t     clk_counter,
  input  logic                      configclk,
  input  pixel_cfg_pkg::array_word_t cfg_array [pixel_cfg_pkg::CFG_WORDS],
  input  logic                      super_pixel_sel,
  output logic                      shift_window,
  output logic                      seq_done,
  output logic                      seq_error,
  output logic                      fw_super_pixel_sel,
  output logic                      fw_config_clk,
  output logic                      fw_reset_not,
  output logic                      fw_config_in,
  output logic                      fw_config_load
);
  import pixel_cfg_pkg::*;

  seq_state_t state;
  chain_t     chain;       // Bit 0 drives config_in
  shift_cnt_t shift_cnt;   // Completed shift periods
  logic       start_pend;  // Waiting for the period boundary
  logic       cfg_err;
  logic       period_end;

  assign cfg_err    = (test_delay == '0) || (test_delay > period) || (test_sample >= test_delay);
  assign period_end = (clk_counter == period);

  // FSM --------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state      <= SEQ_IDLE;
      start_pend <= 1'b0;
      seq_error  <= 1'b0;
      shift_cnt  <= '0;
    end else if (test_start) begin
      state      <= SEQ_IDLE;  // Drops seq_done for the new run
      start_pend <= 1'b1;
      seq_error  <= cfg_err;
      shift_cnt  <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start_pend && seq_error) begin
            state      <= SEQ_DONE;  // Bad config, nothing shifted
            start_pend <= 1'b0;
          end else if (start_pend && period_end) begin
            state      <= test_mask_reset_not ? SEQ_SHIFT : SEQ_RESET_NOT;
            start_pend <= 1'b0;      // Next state begins at counter 0
          end
        end
        SEQ_RESET_NOT: begin
          if (period_end) begin
            state <= SEQ_SHIFT;
          end
        end
        SEQ_SHIFT: begin
          if (period_end) begin
            shift_cnt <= shift_cnt + 1'b1;
            if (shift_cnt == shift_cnt_t'(CHAIN_BITS - 1)) begin
              state <= SEQ_DONE;
            end
          end
        end
        default: state <= state;  // SEQ_DONE holds until the next start
      endcase
    end
  end

  // Chain payload --------------------
  always_ff @(posedge fw_axi_clk) begin
    if (test_start) begin
      for (int i = 0; i < CFG_WORDS; i++) begin
        chain[i*$bits(array_word_t) +: $bits(array_word_t)] <= cfg_array[i];  // Word 0 in LSBs
      end
    end else if (state == SEQ_SHIFT && clk_counter == test_delay) begin
      chain <= {1'b0, chain[CHAIN_BITS-1:1]};  // Once per period
    end
  end

  assign shift_window = (state == SEQ_SHIFT);
  assign seq_done     = (state == SEQ_DONE);

  // Pins parked at 0 while idle
  always_comb begin
    fw_super_pixel_sel = 1'b0;
    fw_config_clk      = 1'b0;
    fw_reset_not       = 1'b0;
    fw_config_in       = 1'b0;
    fw_config_load     = 1'b0;
    if (state != SEQ_IDLE) begin
      fw_super_pixel_sel = super_pixel_sel;
      fw_config_clk      = (state == SEQ_SHIFT) & configclk;
      fw_reset_not       = (state != SEQ_RESET_NOT);
      fw_config_in       = chain[0];
      fw_config_load     = (state != SEQ_SHIFT);  // Low selects shift mode
    end
  end

  a_shift_cnt_max: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    (state == SEQ_SHIFT) |-> (shift_cnt < shift_cnt_t'(CHAIN_BITS)));

endmodule

`default_nettype wire

/* rtl/result_readout.sv */
// Capture register, sticky status word and read data multiplexer
`default_nettype none
`timescale 1ns/100ps

module result_readout (
  input  logic                      fw_axi_clk,
  input  logic                      op_code_w_reset,
  input  logic                      wr_static,
  input  logic                      rd_static,
  input  logic                      wr_array,
  input  logic                      rd_array,
  input  logic                      rd_data,
  input  logic                      status_clear,
  input  logic                      execute,
  input  pixel_cfg_pkg::operand_t    sw_write24_0,
  input  pixel_cfg_pkg::operand_t    static_0,
  input  pixel_cfg_pkg::array_word_t cfg_array [pixel_cfg_pkg::CFG_WORDS],
  input  logic                      shift_window,
  input  pixel_cfg_pkg::period_t     clk_counter,
  input  pixel_cfg_pkg::period_t     test_sample,
  input  logic                      test_loopback,
  input  logic                      fw_config_in,
  input  logic                      fw_config_out,
  input  logic                      seq_done,
  input  logic                      seq_error,
  output pixel_cfg_pkg::data_word_t  fw_read_data32,
  output pixel_cfg_pkg::data_word_t  fw_read_status32
);
  import pixel_cfg_pkg::*;

  chain_t      cap_reg;    // Returned bits, newest at MSB
  array_addr_t arr_addr;
  array_addr_t arr_next;   // Wraps 15 -> 0
  logic [7:0]  rd_index;   // Operand bits 23:16
  cap_addr_t   cap_addr;
  logic        cap_bit;
  logic        done_q;
  logic        done_rise;

  assign arr_addr  = sw_write24_0[ADDR_LSB +: $bits(array_addr_t)];
  assign arr_next  = arr_addr + 1'b1;
  assign rd_index  = sw_write24_0[$bits(operand_t)-1:ADDR_LSB];
  assign cap_addr  = rd_index[$bits(cap_addr_t)-1:0];
  assign cap_bit   = test_loopback ? fw_config_in : fw_config_out;
  assign done_rise = seq_done & ~done_q;

  // Capture --------------------
  always_ff @(posedge fw_axi_clk) begin
    if (shift_window && clk_counter == test_sample) begin
      cap_reg <= {cap_bit, cap_reg[CHAIN_BITS-1:1]};  // Sampled before the shift edge
    end
  end

  // Status --------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      fw_read_status32           <= '0;
      fw_read_status32[ST_RESET] <= 1'b1;
      done_q                     <= 1'b0;
    end else begin
      done_q <= seq_done;
      if (status_clear) begin
        fw_read_status32 <= '0;
      end else begin
        if (wr_static) fw_read_status32[ST_W_STATIC] <= 1'b1;
        if (rd_static) fw_read_status32[ST_R_STATIC] <= 1'b1;
        if (wr_array)  fw_read_status32[ST_W_ARRAY]  <= 1'b1;
        if (rd_array)  fw_read_status32[ST_R_ARRAY]  <= 1'b1;
        if (rd_data)   fw_read_status32[ST_R_DATA]   <= 1'b1;
        if (execute)   fw_read_status32[ST_EXECUTE]  <= 1'b1;
        if (done_rise) begin
          fw_read_status32[ST_DONE] <= 1'b1;
          if (seq_error) begin
            fw_read_status32[ST_ERROR] <= 1'b1;  // Sticky until cleared
          end
        end else if (!seq_done) begin
          fw_read_status32[ST_DONE] <= 1'b0;     // New run started
        end
      end
    end
  end

  // Same-cycle read path
  always_comb begin
    fw_read_data32 = '0;
    if (rd_static) begin
      fw_read_data32 = data_word_t'(static_0);  // Zero padded
    end else if (rd_array) begin
      fw_read_data32 = {cfg_array[arr_next], cfg_array[arr_addr]};
    end else if (rd_data && rd_index < CAP_WORDS) begin
      fw_read_data32 = cap_reg[cap_addr*$bits(data_word_t) +: $bits(data_word_t)];
    end
  end

endmodule

`default_nettype wire

/* rtl/pixel_cfg_top.sv */
// Top level of the pixel configuration tester firmware
`default_nettype none
`timescale 1ns/100ps

module pixel_cfg_top (
  input  logic                     fw_axi_clk,
  input  logic                     op_code_w_reset,
  input  logic                     fw_dev_id_enable,
  input  logic                     fw_op_code_w_cfg_static_0,
  input  logic                     fw_op_code_r_cfg_static_0,
  input  logic                     fw_op_code_w_cfg_array_0,
  input  logic                     fw_op_code_r_cfg_array_0,
  input  logic                     fw_op_code_r_data_array_0,
  input  logic                     fw_op_code_w_status_clear,
  input  logic                     fw_op_code_w_execute,
  input  pixel_cfg_pkg::operand_t   sw_write24_0,
  output pixel_cfg_pkg::data_word_t fw_read_data32,
  output pixel_cfg_pkg::data_word_t fw_read_status32,
  output logic                     fw_super_pixel_sel,
  output logic                     fw_config_clk,
  output logic                     fw_reset_not,
  output logic                     fw_config_in,
  output logic                     fw_config_load,
  input  logic                     fw_config_out
);
  import pixel_cfg_pkg::*;

  logic        wr_static, rd_static, wr_array, rd_array, rd_data, status_clear, execute;
  logic        test_start, test_loopback, test_mask_reset_not;
  period_t     test_delay, test_sample, period, clk_counter;
  operand_t    static_0;
  array_word_t cfg_array [CFG_WORDS];
  logic        super_pixel_sel, configclk;
  logic        shift_window, seq_done, seq_error;

  // Static register 0 fields
  assign period          = static_0[FAST_PERIOD_MSB:FAST_PERIOD_LSB];
  assign super_pixel_sel = static_0[SUPER_PIX_SEL_BIT];

  command_decoder decode_i (
    .fw_axi_clk, .op_code_w_reset, .fw_dev_id_enable,
    .fw_op_code_w_cfg_static_0, .fw_op_code_r_cfg_static_0,
    .fw_op_code_w_cfg_array_0, .fw_op_code_r_cfg_array_0,
    .fw_op_code_r_data_array_0, .fw_op_code_w_status_clear,
    .fw_op_code_w_execute, .sw_write24_0,
    .wr_static, .rd_static, .wr_array, .rd_array, .rd_data, .status_clear, .execute,
    .test_start, .test_delay, .test_sample, .test_loopback, .test_mask_reset_not
  );

  config_regs regs_i (
    .fw_axi_clk, .op_code_w_reset, .wr_static, .wr_array, .sw_write24_0,
    .static_0, .cfg_array
  );

  configclk_generator clkgen_i (
    .fw_axi_clk, .op_code_w_reset, .period, .clk_counter, .configclk
  );

  config_shift_sequencer seq_i (
    .fw_axi_clk, .op_code_w_reset, .test_start, .test_delay, .test_sample,
    .test_mask_reset_not, .period, .clk_counter, .configclk, .cfg_array,
    .super_pixel_sel, .shift_window, .seq_done, .seq_error,
    .fw_super_pixel_sel, .fw_config_clk, .fw_reset_not, .fw_config_in, .fw_config_load
  );

  result_readout readout_i (
    .fw_axi_clk, .op_code_w_reset,
    .wr_static, .rd_static, .wr_array, .rd_array, .rd_data, .status_clear, .execute,
    .sw_write24_0, .static_0, .cfg_array, .shift_window, .clk_counter,
    .test_sample, .test_loopback, .fw_config_in, .fw_config_out,
    .seq_done, .seq_error, .fw_read_data32, .fw_read_status32
  );

endmodule

`default_nettype wire

/* tb/tb_pixel_cfg_top.sv */
// Random-stimulus testbench with reference model and ASIC chain model for pixel_cfg_top
`default_nettype none
`timescale 1ns/100ps

module tb_pixel_cfg_top;
  import pixel_cfg_pkg::*;

  localparam int TIMEOUT         = 20000;  // Cycles allowed for one chain test
  localparam int OP_W_STATIC     = 0;      // Strobe vector bit order
  localparam int OP_R_STATIC     = 1;
  localparam int OP_W_ARRAY      = 2;
  localparam int OP_R_ARRAY      = 3;
  localparam int OP_R_DATA       = 4;
  localparam int OP_STATUS_CLEAR = 5;
  localparam int OP_EXECUTE      = 6;

  logic       fw_axi_clk;
  logic       op_code_w_reset;
  logic       fw_dev_id_enable;
  logic [6:0] strobe;  // One bit per op-code
  operand_t   sw_write24_0;
  data_word_t fw_read_data32;
  data_word_t fw_read_status32;
  logic       fw_super_pixel_sel, fw_config_clk, fw_reset_not, fw_config_in, fw_config_load;
  logic       fw_config_out;

  // Reference model state
  operand_t    static_exp;
  array_word_t arr_exp [CFG_WORDS];
  data_word_t  st_exp;
  chain_t      cap_exp;     // Expected capture register
  data_word_t  rd_val;      // Read data seen during the last op
  int          check_errs;
  int          timeout_errs;

  assign fw_config_out = ~fw_config_in;  // ASIC chain returns inverted bits

  always #5 fw_axi_clk = ~fw_axi_clk;   // 10 ns

  pixel_cfg_top dut_i (
    .fw_axi_clk, .op_code_w_reset, .fw_dev_id_enable,
    .fw_op_code_w_cfg_static_0 (strobe[OP_W_STATIC]),
    .fw_op_code_r_cfg_static_0 (strobe[OP_R_STATIC]),
    .fw_op_code_w_cfg_array_0  (strobe[OP_W_ARRAY]),
    .fw_op_code_r_cfg_array_0  (strobe[OP_R_ARRAY]),
    .fw_op_code_r_data_array_0 (strobe[OP_R_DATA]),
    .fw_op_code_w_status_clear (strobe[OP_STATUS_CLEAR]),
    .fw_op_code_w_execute      (strobe[OP_EXECUTE]),
    .sw_write24_0, .fw_read_data32, .fw_read_status32,
    .fw_super_pixel_sel, .fw_config_clk, .fw_reset_not, .fw_config_in, .fw_config_load,
    .fw_config_out
  );

  // Helpers --------------------
  task automatic report_mismatch(input string name, input data_word_t exp, input data_word_t act);
    $display("** Error %s: expected %h, actual %h", name, exp, act);
    check_errs++;
  endtask

  function automatic int status_bit(input int code);
    case (code)
      OP_W_STATIC: return ST_W_STATIC;
      OP_R_STATIC: return ST_R_STATIC;
      OP_W_ARRAY:  return ST_W_ARRAY;
      OP_R_ARRAY:  return ST_R_ARRAY;
      OP_R_DATA:   return ST_R_DATA;
      default:     return ST_EXECUTE;
    endcase
  endfunction

  // Reset held for 2 cycles, then status and pins checked
  task automatic apply_reset();
    @(posedge fw_axi_clk);
    op_code_w_reset <= 1'b1;
    repeat (2) @(posedge fw_axi_clk);
    op_code_w_reset <= 1'b0;
    static_exp = '0;
    for (int i = 0; i < CFG_WORDS; i++) arr_exp[i] = '0;
    st_exp = data_word_t'(1) << ST_RESET;  // Only the reset bit
    @(negedge fw_axi_clk);
    if (fw_read_status32 !== st_exp) report_mismatch("reset status", st_exp, fw_read_status32);
    if ({fw_super_pixel_sel, fw_config_clk, fw_reset_not, fw_config_in, fw_config_load} !== 5'b0)
      report_mismatch("reset pins", '0, {27'b0, fw_super_pixel_sel, fw_config_clk,
                      fw_reset_not, fw_config_in, fw_config_load});
  endtask

  // One op-code strobe for one cycle, model update, status check
  task automatic issue_op(input int code, input operand_t val, input logic en, input string name);
    @(posedge fw_axi_clk);
    strobe[code]     <= 1'b1;
    sw_write24_0     <= val;
    fw_dev_id_enable <= en;
    @(negedge fw_axi_clk);
    rd_val = fw_read_data32;  // Combinational read path
    @(posedge fw_axi_clk);
    strobe <= '0;
    if (en) begin
      if (code == OP_STATUS_CLEAR) st_exp = '0;
      else st_exp[status_bit(code)] = 1'b1;
      if (code == OP_W_STATIC) static_exp = val;
      if (code == OP_W_ARRAY) arr_exp[val[19:16]] = val[15:0];
    end
    @(negedge fw_axi_clk);
    if (fw_read_status32 !== st_exp) report_mismatch({name, " status"}, st_exp, fw_read_status32);
  endtask

  task automatic fill_array();
    operand_t val;
    for (int i = 0; i < CFG_WORDS; i++) begin
      val        = operand_t'($urandom);
      val[19:16] = 4'(i);  // Word index
      issue_op(OP_W_ARRAY, val, 1'b1, "array write");
    end
  endtask

  // Chain test --------------------
  task automatic run_chain(input string name, input logic mask, input logic loopback,
                           input period_t delay, input period_t sample);
    int       cycles;
    int       rst_low;     // Reset pulse length in cycles
    int       clk_rises;
    int       exp_rst;
    logic     clk_q;
    logic     bad_cfg;
    chain_t   chain;
    operand_t val;
    cycles    = 0;
    rst_low   = 0;
    clk_rises = 0;
    clk_q     = 1'b0;
    bad_cfg   = (delay == 0) || (delay > static_exp[6:0]) || (sample >= delay);
    issue_op(OP_STATUS_CLEAR, '0, 1'b1, {name, " clear"});
    issue_op(OP_EXECUTE, {mask, 4'b0, loopback, TEST_SHIFT_CHAIN, sample, delay}, 1'b1, name);
    while (!fw_read_status32[ST_DONE] && cycles < TIMEOUT) begin
      @(negedge fw_axi_clk);
      cycles++;
      if (!fw_reset_not && fw_config_load && clk_rises == 0) rst_low++;  // Pulse before clocks
      if (fw_config_clk && !clk_q) clk_rises++;
      clk_q = fw_config_clk;
    end
    if (!fw_read_status32[ST_DONE]) begin
      $display("Timeout: %s did not set the done bit within %0d cycles", name, TIMEOUT);
      timeout_errs++;
    end
    st_exp[ST_DONE] = 1'b1;
    if (bad_cfg) st_exp[ST_ERROR] = 1'b1;
    if (fw_read_status32 !== st_exp) report_mismatch({name, " done status"}, st_exp,
                                                     fw_read_status32);
    exp_rst = (bad_cfg || mask) ? 0 : int'(static_exp[6:0]) + 1;  // One configclk period
    if (rst_low != exp_rst) report_mismatch({name, " reset_not cycles"}, exp_rst, rst_low);
    if (clk_rises != (bad_cfg ? 0 : CHAIN_BITS))
      report_mismatch({name, " config_clk edges"}, bad_cfg ? 0 : CHAIN_BITS, clk_rises);
    if ({fw_super_pixel_sel, fw_config_clk, fw_reset_not, fw_config_load} !==
        {static_exp[SUPER_PIX_SEL_BIT], 3'b011})  // Done state pins
      report_mismatch({name, " done pins"}, {static_exp[SUPER_PIX_SEL_BIT], 3'b011},
                      {fw_super_pixel_sel, fw_config_clk, fw_reset_not, fw_config_load});
    if (!bad_cfg) begin
      for (int i = 0; i < CFG_WORDS; i++) chain[i*16 +: 16] = arr_exp[i];
      cap_exp = loopback ? chain : ~chain;  // ASIC model inverts
    end
    for (int k = 0; k < CAP_WORDS; k++) begin
      val        = operand_t'($urandom);
      val[23:16] = 8'(k);
      issue_op(OP_R_DATA, val, 1'b1, {name, " capture read"});
      if (rd_val !== cap_exp[k*32 +: 32]) report_mismatch({name, " capture word"},
                                                          cap_exp[k*32 +: 32], rd_val);
    end
    val        = operand_t'($urandom);
    val[23:16] = 8'(CAP_WORDS + $urandom_range(255 - CAP_WORDS));  // Out of range index
    issue_op(OP_R_DATA, val, 1'b1, {name, " high index read"});
    if (rd_val !== '0) report_mismatch({name, " high index read"}, '0, rd_val);
  endtask

  // Stimulus --------------------
  initial begin
    operand_t val;
    period_t  per;
    period_t  delay;
    period_t  sample;
    fw_axi_clk       = 1'b0;
    op_code_w_reset  = 1'b0;
    fw_dev_id_enable = 1'b0;
    strobe           = '0;
    sw_write24_0     = '0;
    check_errs       = 0;
    timeout_errs     = 0;
    cap_exp          = '0;
    void'($urandom(32'h6db9));
    apply_reset();

    // Static register 0 with and without device enable
    val = operand_t'($urandom);
    issue_op(OP_W_STATIC, val, 1'b1, "static write");
    issue_op(OP_R_STATIC, '0, 1'b1, "static read");
    if (rd_val !== {8'h0, static_exp}) report_mismatch("static read", {8'h0, static_exp}, rd_val);
    issue_op(OP_W_STATIC, ~val, 1'b0, "disabled static write");
    issue_op(OP_R_STATIC, '0, 1'b1, "static read after disabled write");
    if (rd_val !== {8'h0, val}) report_mismatch("disabled static write", {8'h0, val}, rd_val);

    // Array pairs, 15 pairs with 0
    fill_array();
    for (int i = 0; i < CFG_WORDS; i++) begin
      val        = operand_t'($urandom);
      val[19:16] = 4'(i);
      issue_op(OP_R_ARRAY, val, 1'b1, "array read");
      if (rd_val !== {arr_exp[(i + 1) % CFG_WORDS], arr_exp[i]})
        report_mismatch("array read", {arr_exp[(i + 1) % CFG_WORDS], arr_exp[i]}, rd_val);
    end

    // Sticky bit per strobe
    for (int c = 0; c < 7; c++) begin
      issue_op(OP_STATUS_CLEAR, '0, 1'b1, "status clear");
      val        = operand_t'($urandom);
      val[17:14] = 4'd0;  // No chain test
      issue_op(c, val, 1'b1, "status bit");
    end

    // Loopback runs, then inverted runs with and without the reset pulse
    for (int t = 0; t < 5; t++) begin
      fill_array();
      per    = period_t'(4 + $urandom_range(11));
      val    = operand_t'($urandom);
      val[6:0] = per;
      issue_op(OP_W_STATIC, val, 1'b1, "static period write");
      delay  = period_t'(1 + $urandom_range(per - 1));
      sample = period_t'($urandom_range(delay - 1));
      if (t < 3) run_chain("loopback chain", $urandom_range(1), 1'b1, delay, sample);
      else run_chain("inverted chain", t[0], 1'b0, delay, sample);
    end

    // Sample not below delay, loopback so a stray shift would alter the inverted capture
    run_chain("bad config", 1'b0, 1'b1, delay, delay + period_t'($urandom_range(100)));

    apply_reset();
    issue_op(OP_R_STATIC, '0, 1'b1, "static read after reset");
    if (rd_val !== '0) report_mismatch("static read after reset", '0, rd_val);

    $display("Checks done: %0d value errors, %0d timeouts", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/pixel_cfg_pkg.sv
rtl/command_decoder.sv
rtl/config_regs.sv
rtl/configclk_generator.sv
rtl/config_shift_sequencer.sv
rtl/result_readout.sv
rtl/pixel_cfg_top.sv
tb/tb_pixel_cfg_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the pixel configuration tester testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_pixel_cfg_top \
  -f filelist.f -o tb_pixel_cfg_top
out=$(./obj_dir/tb_pixel_cfg_top)
echo "$out"
echo "$out" | grep -q 'All tests passed!'
